/* Bender.yml */
package:
  name: dec_stage

sources:
  - src/dec_pkg.sv
  - src/dec_ib.sv
  - src/dec_slot.sv
  - src/dec_gpr.sv
  - src/dec_issue.sv
  - src/dec_top.sv
  - target: test
    files:
      - testbench/tb_dec.sv

/* flist.f */
src/dec_pkg.sv
src/dec_ib.sv
src/dec_slot.sv
src/dec_gpr.sv
src/dec_issue.sv
src/dec_top.sv
testbench/tb_dec.sv

/* src/dec_gpr.sv */
`timescale 1ns/1ps
//**************************************************
// integer register file with x0 fixed at zero
// four read ports and one writeback port
//**************************************************
module dec_gpr (
   input  logic                                                   clk,
   input  logic [dec_pkg::num_rd_ports-1:0][dec_pkg::reg_addr_w-1:0] raddr,
   input  dec_pkg::wb_pkt_t                                       wb,
   output logic [dec_pkg::num_rd_ports-1:0][dec_pkg::xlen-1:0]    rdata
);

   logic [dec_pkg::xlen-1:0] regs [dec_pkg::num_regs-1:1];   // x1..x31 only
   logic                     wr_en;

   assign wr_en = wb.valid & (wb.rd != '0);                  // writes to x0 dropped

   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[wb.rd] <= wb.data;
      end
   end

   for (genvar p = 0; p < dec_pkg::num_rd_ports; p++) begin : g_rd
      always_comb begin
         if (raddr[p] == '0) begin
            rdata[p] = '0;
         end else if (wr_en && wb.rd == raddr[p]) begin
            rdata[p] = wb.data;                              // write-through
         end else begin
            rdata[p] = regs[raddr[p]];
         end
      end

      // holds even when writeback targets x0 in the same cycle
      assert property (@(posedge clk) (raddr[p] == '0) |-> (rdata[p] == '0))
         else $error("x0 read returned nonzero on port %0d", p);
   end

endmodule

/* src/dec_ib.sv */
`timescale 1ns/1ps
//**************************************************
// two-entry buffer of fetched instruction pairs
// slots drain one at a time through consume
//**************************************************
module dec_ib (
   input  logic                                             clk,
   input  logic                                             rst_n,
   input  logic                                             fetch_valid,
   input  dec_pkg::fetch_pkt_t                              fetch_pkt,
   input  logic [dec_pkg::num_slots-1:0]                    consume,
   output logic                                             fetch_ready,
   output logic [dec_pkg::num_slots-1:0][dec_pkg::xlen-1:0] head_instr,
   output logic [dec_pkg::num_slots-1:0]                    head_valid
);

   logic [dec_pkg::num_slots-1:0][dec_pkg::xlen-1:0] ent_instr [dec_pkg::ib_depth]; // payload
   logic [dec_pkg::num_slots-1:0] ent_valid [dec_pkg::ib_depth]; // slot valids per entry
   logic [dec_pkg::ib_ptr_w-1:0]  rd_ptr;        // head entry
   logic [dec_pkg::ib_ptr_w-1:0]  wr_ptr;        // next free entry
   logic [dec_pkg::ib_cnt_w-1:0]  count;         // occupied entries
   logic                          push;
   logic                          retire;
   logic [dec_pkg::num_slots-1:0] head_left;     // head slots still waiting

   assign fetch_ready = (count < dec_pkg::ib_depth);         // room for one more pair
   assign push        = fetch_valid & fetch_ready & (|fetch_pkt.valid); // empty pair not stored
   assign head_instr  = ent_instr[rd_ptr];
   assign head_valid  = ent_valid[rd_ptr];                   // zero when buffer empty
   assign head_left   = head_valid & ~consume;
   assign retire      = (|consume) & ~(|head_left);          // last slot of head going out

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
         for (int e = 0; e < dec_pkg::ib_depth; e++) begin
            ent_valid[e] <= '0;
         end
      end else begin
         if (push) begin
            ent_valid[wr_ptr] <= fetch_pkt.valid;            // invalid slots dropped here
            wr_ptr <= (int'(wr_ptr) == dec_pkg::ib_depth - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (|consume) begin
            ent_valid[rd_ptr] <= head_left;                  // clear consumed slots
         end
         if (retire) begin
            rd_ptr <= (int'(rd_ptr) == dec_pkg::ib_depth - 1) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, retire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                         // none or both
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         ent_instr[wr_ptr] <= fetch_pkt.instr;
      end
   end

   // issue stage only takes slots the buffer is presenting
   assert property (@(posedge clk) disable iff (!rst_n) (consume & ~head_valid) == '0)
      else $error("consume of a slot that is not valid");

   assert property (@(posedge clk) disable iff (!rst_n) count <= dec_pkg::ib_depth)
      else $error("buffer occupancy above depth");

endmodule

/* src/dec_issue.sv */
`timescale 1ns/1ps
//**************************************************
// slot dependency check, operand select and the
// registered issue pair toward execution
//**************************************************
module dec_issue (
   input  logic                                                clk,
   input  logic                                                rst_n,
   input  dec_pkg::dec_pkt_t [dec_pkg::num_slots-1:0]          dec,
   input  logic [dec_pkg::num_rd_ports-1:0][dec_pkg::xlen-1:0] rdata,
   input  logic                                                issue_ready,
   output logic [dec_pkg::num_slots-1:0]                       consume,
   output logic                                                issue_valid,
   output dec_pkg::issue_pkt_t [dec_pkg::num_slots-1:0]        issue_pkt
);

   logic                                        s0_writes;  // slot 0 has a real rd
   logic                                        dep;        // slot 1 reads slot 0 rd
   logic                                        load_en;    // issue reg free this edge
   logic [dec_pkg::num_slots-1:0]               sel;        // slots going out
   dec_pkg::issue_pkt_t [dec_pkg::num_slots-1:0] lane_nxt;

   function automatic dec_pkg::issue_pkt_t build_lane(
      input dec_pkg::dec_pkt_t        d,
      input logic [dec_pkg::xlen-1:0] rs1_data,
      input logic [dec_pkg::xlen-1:0] rs2_data,
      input logic                     lane_valid
   );
      dec_pkg::issue_pkt_t p;
      p.valid     = lane_valid;
      p.op        = d.op;
      p.rd        = d.rd;
      p.rd_wr     = d.rd_wr;
      p.operand_a = rs1_data;
      p.operand_b = d.imm_sel ? d.imm : rs2_data;
      case (d.op)
         dec_pkg::lui: p.operand_a = '0;          // imm already shifted by 12
         dec_pkg::illegal: begin
            p.operand_a = '0;
            p.operand_b = '0;
            p.rd_wr     = 1'b0;
         end
         default: ;
      endcase
      return p;
   endfunction

   //**************************************************
   // slot selection
   //**************************************************
   assign s0_writes = dec[0].valid & dec[0].rd_wr & (dec[0].rd != '0);
   assign dep       = s0_writes &
                      ((dec[1].rs1_use & (dec[1].rs1 == dec[0].rd)) |
                       (dec[1].rs2_use & (dec[1].rs2 == dec[0].rd)));
   assign load_en   = ~issue_valid | issue_ready;
   assign sel[0]    = dec[0].valid;
   assign sel[1]    = dec[1].valid & ~dep;          // waits behind its producer
   assign consume   = load_en ? sel : '0;

   for (genvar s = 0; s < dec_pkg::num_slots; s++) begin : g_lane
      assign lane_nxt[s] = build_lane(dec[s], rdata[2*s], rdata[2*s+1], sel[s]); // lane = slot
   end

   //**************************************************
   // issue register
   //**************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         issue_valid <= 1'b0;
      end else if (load_en) begin
         issue_valid <= |sel;
      end
   end

   always_ff @(posedge clk) begin
      if (load_en) begin
         issue_pkt <= lane_nxt;
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n)
                    (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue_pkt)))
      else $error("issue pair changed while stalled");

endmodule

/* src/dec_pkg.sv */
//**************************************************
// shared widths, opcode enum and packet structs
// for the dual-issue decode stage
//**************************************************
package dec_pkg;

   localparam int xlen         = 32;                  // data width
   localparam int num_slots    = 2;                   // instructions per fetch pair
   localparam int num_regs     = 32;                  // general registers
   localparam int reg_addr_w   = 5;                   // register address width
   localparam int ib_depth     = 2;                   // buffer entries
   localparam int ib_ptr_w     = $clog2(ib_depth);    // buffer pointer width
   localparam int ib_cnt_w     = $clog2(ib_depth + 1); // occupancy counter width
   localparam int num_rd_ports = 2 * num_slots;       // rs1 and rs2 per slot

   // RV32I major opcodes kept by the decoder
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_lui    = 7'b0110111;

   //**************************************************
   // decoded operations
   //**************************************************
   typedef enum logic [4:0] {
      add, sub, and_op, or_op, xor_op, slt, sltu, sll, srl, sra,
      addi, andi, ori, xori, slti, lui, illegal
   } dec_op_e;

   typedef struct packed {
      logic [num_slots-1:0]           valid;  // per-slot valid
      logic [num_slots-1:0][xlen-1:0] instr;  // slot 0 in low word
   } fetch_pkt_t;

   typedef struct packed {
      logic                  valid;
      dec_op_e               op;
      logic [reg_addr_w-1:0] rs1;
      logic                  rs1_use;   // rs1 read by this op
      logic [reg_addr_w-1:0] rs2;
      logic                  rs2_use;   // rs2 read by this op
      logic [reg_addr_w-1:0] rd;
      logic                  rd_wr;     // op writes rd
      logic [xlen-1:0]       imm;       // sign-extended I or U immediate
      logic                  imm_sel;   // operand b from imm
   } dec_pkt_t;

   typedef struct packed {
      logic                  valid;
      dec_op_e               op;
      logic [reg_addr_w-1:0] rd;
      logic                  rd_wr;
      logic [xlen-1:0]       operand_a;
      logic [xlen-1:0]       operand_b;
   } issue_pkt_t;

   typedef struct packed {
      logic                  valid;
      logic [reg_addr_w-1:0] rd;
      logic [xlen-1:0]       data;
   } wb_pkt_t;

endpackage

/* src/dec_slot.sv */
`timescale 1ns/1ps
//**************************************************
// single-slot decoder for the RV32I integer subset
// one instance per fetch slot
//**************************************************
module dec_slot (
   input  logic [dec_pkg::xlen-1:0] instr,
   input  logic                     instr_valid,
   output dec_pkg::dec_pkt_t        dec
);

   logic [6:0]         opcode;
   logic [2:0]         funct3;
   logic [6:0]         funct7;
   dec_pkg::dec_op_e   op;
   logic               is_op;       // register-register
   logic               is_op_imm;   // register-immediate
   logic               is_lui;

   assign opcode    = instr[6:0];
   assign funct3    = instr[14:12];
   assign funct7    = instr[31:25];
   assign is_op     = (opcode == dec_pkg::opc_op);
   assign is_op_imm = (opcode == dec_pkg::opc_op_imm);
   assign is_lui    = (opcode == dec_pkg::opc_lui);

   //**************************************************
   // opcode select
   //**************************************************
   always_comb begin
      op = dec_pkg::illegal;                   // anything not matched below
      if (is_op && funct7 == 7'b0000000) begin
         case (funct3)
            3'b000: op = dec_pkg::add;
            3'b001: op = dec_pkg::sll;
            3'b010: op = dec_pkg::slt;
            3'b011: op = dec_pkg::sltu;
            3'b100: op = dec_pkg::xor_op;
            3'b101: op = dec_pkg::srl;
            3'b110: op = dec_pkg::or_op;
            default: op = dec_pkg::and_op;     // 3'b111
         endcase
      end else if (is_op && funct7 == 7'b0100000) begin
         if (funct3 == 3'b000) begin
            op = dec_pkg::sub;
         end else if (funct3 == 3'b101) begin
            op = dec_pkg::sra;
         end
      end else if (is_op_imm) begin
         case (funct3)
            3'b000: op = dec_pkg::addi;
            3'b010: op = dec_pkg::slti;
            3'b100: op = dec_pkg::xori;
            3'b110: op = dec_pkg::ori;
            3'b111: op = dec_pkg::andi;
            default: op = dec_pkg::illegal;    // shifts and sltiu not in subset
         endcase
      end else if (is_lui) begin
         op = dec_pkg::lui;
      end
   end

   //**************************************************
   // packet build
   //**************************************************
   always_comb begin
      dec.valid   = instr_valid;
      dec.op      = op;
      dec.rs1     = instr[19:15];
      dec.rs2     = instr[24:20];
      dec.rd      = instr[11:7];
      dec.rs1_use = instr_valid & (op != dec_pkg::illegal) & (is_op | is_op_imm);
      dec.rs2_use = instr_valid & (op != dec_pkg::illegal) & is_op;
      dec.rd_wr   = instr_valid & (op != dec_pkg::illegal);   // illegal never writes
      dec.imm_sel = is_op_imm | is_lui;
      if (is_lui) begin
         dec.imm = {instr[31:12], 12'b0};                      // U-type
      end else begin
         dec.imm = {{20{instr[31]}}, instr[31:20]};            // I-type sign extend
      end
   end

endmodule

/* src/dec_top.sv */
`timescale 1ns/1ps
//**************************************************
// dual-issue decode top: buffer, slot decoders,
// register file and issue stage
//**************************************************
module dec_top (
   input  logic                                         clk,
   input  logic                                         rst_n,
   input  logic                                         fetch_valid,
   input  dec_pkg::fetch_pkt_t                          fetch_pkt,
   input  dec_pkg::wb_pkt_t                             wb,
   input  logic                                         issue_ready,
   output logic                                         fetch_ready,
   output logic                                         issue_valid,
   output dec_pkg::issue_pkt_t [dec_pkg::num_slots-1:0] issue_pkt
);

   logic [dec_pkg::num_slots-1:0][dec_pkg::xlen-1:0]       head_instr;
   logic [dec_pkg::num_slots-1:0]                          head_valid;
   logic [dec_pkg::num_slots-1:0]                          consume;
   dec_pkg::dec_pkt_t [dec_pkg::num_slots-1:0]             dec;
   logic [dec_pkg::num_rd_ports-1:0][dec_pkg::reg_addr_w-1:0] raddr;
   logic [dec_pkg::num_rd_ports-1:0][dec_pkg::xlen-1:0]    rdata;

   dec_ib u_ib (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_valid (fetch_valid),
      .fetch_pkt   (fetch_pkt),
      .consume     (consume),
      .fetch_ready (fetch_ready),
      .head_instr  (head_instr),
      .head_valid  (head_valid)
   );

   for (genvar s = 0; s < dec_pkg::num_slots; s++) begin : g_slot
      dec_slot u_slot (
         .instr       (head_instr[s]),
         .instr_valid (head_valid[s]),
         .dec         (dec[s])
      );
      assign raddr[2*s]   = dec[s].rs1;   // even ports rs1
      assign raddr[2*s+1] = dec[s].rs2;   // odd ports rs2
   end

   dec_gpr u_gpr (
      .clk   (clk),
      .raddr (raddr),
      .wb    (wb),
      .rdata (rdata)
   );

   dec_issue u_issue (
      .clk         (clk),
      .rst_n       (rst_n),
      .dec         (dec),
      .rdata       (rdata),
      .issue_ready (issue_ready),
      .consume     (consume),
      .issue_valid (issue_valid),
      .issue_pkt   (issue_pkt)
   );

endmodule

/* testbench/tb_dec.sv */
`timescale 1ns/1ps
//**************************************************
// self-checking testbench for the decode stage top
// random programs checked against a register model
//**************************************************
module tb_dec;

   localparam int num_pairs   = 154;                  // pairs fetched over all tests
   localparam int cycle_limit = 16 + 20 * num_pairs;  // reset plus 20 per pair

   typedef dec_pkg::issue_pkt_t [dec_pkg::num_slots-1:0] lanes_t;

   typedef struct packed {
      lanes_t lanes;
      logic   last;                                   // final transfer of its pair
   } exp_t;

   typedef struct packed {
      logic [31:0]      instr;
      dec_pkg::dec_op_e op;
      logic [4:0]       rd;
      logic [4:0]       rs1;
      logic [4:0]       rs2;
      logic [19:0]      imm;                          // low 12 bits for I-type
   } slot_t;

   logic                clk;
   logic                rst_n;
   logic                fetch_valid;
   dec_pkg::fetch_pkt_t fetch_pkt;
   dec_pkg::wb_pkt_t    wb;
   logic                issue_ready;
   logic                fetch_ready;
   logic                issue_valid;
   lanes_t              issue_pkt;

   logic [31:0] regs_m [dec_pkg::num_regs];           // reference register values
   exp_t        expq [$];                             // expected transfers in order
   lanes_t      exp_cur;                              // head of expq
   logic        exp_any;
   int          outstanding;                          // accepted pairs not fully issued
   logic [31:0] seed;
   logic        rand_ready;                           // random back-pressure on
   int          errors;
   int          err_start;
   int          n_pass;
   int          n_fail;

   dec_top DUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_valid (fetch_valid),
      .fetch_pkt   (fetch_pkt),
      .wb          (wb),
      .issue_ready (issue_ready),
      .fetch_ready (fetch_ready),
      .issue_valid (issue_valid),
      .issue_pkt   (issue_pkt)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //**************************************************
   // stimulus helpers and reference model
   //**************************************************
   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;   // LCG step
      return seed;
   endfunction

   function automatic dec_pkg::dec_op_e rand_op(input int n);
      logic [31:0] r;
      r = next_rand();
      return dec_pkg::dec_op_e'(5'(r[31:8] % n));   // first n ops of the enum
   endfunction

   function automatic logic is_rr(input dec_pkg::dec_op_e op);
      return op inside {dec_pkg::add, dec_pkg::sub, dec_pkg::and_op, dec_pkg::or_op,
                        dec_pkg::xor_op, dec_pkg::slt, dec_pkg::sltu, dec_pkg::sll,
                        dec_pkg::srl, dec_pkg::sra};
   endfunction

   function automatic logic is_ri(input dec_pkg::dec_op_e op);
      return op inside {dec_pkg::addi, dec_pkg::andi, dec_pkg::ori, dec_pkg::xori,
                        dec_pkg::slti};
   endfunction

   function automatic slot_t encode(input slot_t s);
      logic [2:0] f3;
      logic [6:0] f7;
      case (s.op)
         dec_pkg::sll:                     f3 = 3'd1;
         dec_pkg::slt, dec_pkg::slti:      f3 = 3'd2;
         dec_pkg::sltu:                    f3 = 3'd3;
         dec_pkg::xor_op, dec_pkg::xori:   f3 = 3'd4;
         dec_pkg::srl, dec_pkg::sra:       f3 = 3'd5;
         dec_pkg::or_op, dec_pkg::ori:     f3 = 3'd6;
         dec_pkg::and_op, dec_pkg::andi:   f3 = 3'd7;
         default:                          f3 = 3'd0;
      endcase
      f7 = (s.op inside {dec_pkg::sub, dec_pkg::sra}) ? 7'h20 : 7'h00;
      if (is_rr(s.op)) begin
         s.instr = {f7, s.rs2, s.rs1, f3, s.rd, 7'h33};
      end else if (is_ri(s.op)) begin
         s.instr = {s.imm[11:0], s.rs1, f3, s.rd, 7'h13};
      end else if (s.op == dec_pkg::lui) begin
         s.instr = {s.imm, s.rd, 7'h37};
      end else if (s.imm[19:18] == 2'd0) begin
         s.instr = {7'h01, s.rs2, s.rs1, s.imm[2:0], s.rd, 7'h33};   // M extension
      end else if (s.imm[19:18] == 2'd1) begin
         s.instr = {s.imm[11:0], s.rs1, s.imm[2:0], s.rd, 7'h03};   // load
      end else begin
         s.instr = {s.imm[11:0], s.rs1, {s.imm[0], 2'b01}, s.rd, 7'h13}; // shift imm
      end
      return s;
   endfunction

   function automatic slot_t rand_slot(input dec_pkg::dec_op_e op);
      slot_t       s;
      logic [31:0] r;
      r     = next_rand();
      s.op  = op;
      s.rd  = r[11:7];
      s.rs1 = r[19:15];
      s.rs2 = r[24:20];
      r     = next_rand();
      s.imm = r[31:12];
      return encode(s);
   endfunction

   function automatic dec_pkg::issue_pkt_t exp_lane(input slot_t s, input logic valid);
      dec_pkg::issue_pkt_t p;
      p       = '0;
      p.valid = valid;
      p.op    = s.op;
      p.rd    = s.rd;
      p.rd_wr = (s.op != dec_pkg::illegal);
      if (is_rr(s.op)) begin
         p.operand_a = regs_m[s.rs1];
         p.operand_b = regs_m[s.rs2];
      end else if (is_ri(s.op)) begin
         p.operand_a = regs_m[s.rs1];
         p.operand_b = {{20{s.imm[11]}}, s.imm[11:0]};   // sign-extended imm
      end else if (s.op == dec_pkg::lui) begin
         p.operand_b = {s.imm, 12'h000};
      end
      return p;
   endfunction

   function automatic logic reads_reg(input slot_t s, input logic [4:0] r);
      if (is_rr(s.op)) begin
         return (s.rs1 == r) || (s.rs2 == r);
      end else if (is_ri(s.op)) begin
         return s.rs1 == r;
      end
      return 1'b0;                                      // lui and illegal read nothing
   endfunction

   function automatic logic pair_ok(input lanes_t act, input lanes_t exp);
      logic ok;
      ok = 1'b1;
      for (int l = 0; l < dec_pkg::num_slots; l++) begin
         if (act[l].valid !== exp[l].valid) begin
            ok = 1'b0;
         end else if (exp[l].valid && act[l] !== exp[l]) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   task automatic refresh_head();
      exp_any = (expq.size() != 0);
      exp_cur = exp_any ? expq[0].lanes : '0;
   endtask

   task automatic push_expected(input slot_t s0, input slot_t s1, input logic [1:0] v);
      exp_t e0;
      exp_t e1;
      logic dep;
      dep = (v == 2'b11) && (s0.op != dec_pkg::illegal) && (s0.rd != 5'd0) &&
            reads_reg(s1, s0.rd);
      e0.lanes[0] = exp_lane(s0, v[0]);
      e0.lanes[1] = exp_lane(s1, v[1] && !dep);     // slot 1 waits on a split
      e0.last     = !dep;
      e1.lanes[0] = exp_lane(s0, 1'b0);
      e1.lanes[1] = exp_lane(s1, 1'b1);
      e1.last     = 1'b1;
      if (v != 2'b00) begin
         expq.push_back(e0);
      end
      if (dep) begin
         expq.push_back(e1);
      end
      refresh_head();
   endtask

   task automatic step();
      logic [31:0] r;
      @(negedge clk);
      r           = next_rand();
      issue_ready = rand_ready ? r[24] : 1'b1;
   endtask

   task automatic send_pair(input slot_t s0, input slot_t s1, input logic [1:0] v);
      step();
      fetch_valid     = 1'b1;
      fetch_pkt.valid = v;
      fetch_pkt.instr = {s1.instr, s0.instr};       // slot 0 in low word
      while (!fetch_ready) begin
         step();
      end
      push_expected(s0, s1, v);                     // taken on the next rising edge
   endtask

   task automatic finish_test(input string name);
      step();
      fetch_valid = 1'b0;
      rand_ready  = 1'b0;
      while (expq.size() != 0) begin
         step();
      end
      repeat (3) step();                            // catch stray transfers
      if (errors == err_start) begin
         n_pass++;
         $display("test %s: pass", name);
      end else begin
         n_fail++;
         $display("test %s: fail with %0d errors", name, errors - err_start);
      end
      err_start = errors;
   endtask

   //**************************************************
   // transfer tracking and checks
   //**************************************************
   always @(posedge clk) begin
      if (rst_n) begin
         if (fetch_valid && fetch_ready && (|fetch_pkt.valid)) begin
            outstanding++;
         end
         if (issue_valid && issue_ready && exp_any) begin
            if (expq[0].last) begin
               outstanding--;
            end
            expq.delete(0);
            refresh_head();
         end
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n)
                    (issue_valid && issue_ready) |-> (exp_any && pair_ok(issue_pkt, exp_cur)))
      else begin
         $display("Error: %0t ns: issue transfer differs from expected pair", $time);
         errors++;
      end

   assert property (@(posedge clk) disable iff (!rst_n)
                    (issue_valid && !issue_ready) |=> $stable(issue_pkt))
      else begin
         $display("Error: %0t ns: issue pair changed while stalled", $time);
         errors++;
      end

   // three pairs in flight means both buffer entries are taken
   assert property (@(posedge clk) disable iff (!rst_n) (outstanding >= 3) |-> !fetch_ready)
      else begin
         $display("Error: %0t ns: fetch_ready high with buffer full", $time);
         errors++;
      end

   initial begin
      int cycles;
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
   end

   //**************************************************
   // test sequence
   //**************************************************
   initial begin
      slot_t s0;
      slot_t s1;
      seed        = 32'hf8c4fb02;
      rst_n       = 1'b0;
      fetch_valid = 1'b0;
      fetch_pkt   = '0;
      wb          = '0;
      issue_ready = 1'b1;
      rand_ready  = 1'b0;
      errors      = 0;
      err_start   = 0;
      n_pass      = 0;
      n_fail      = 0;
      outstanding = 0;
      exp_any     = 1'b0;
      exp_cur     = '0;
      for (int r = 0; r < dec_pkg::num_regs; r++) begin
         regs_m[r] = '0;
      end
      repeat (16) @(posedge clk);
      step();
      rst_n = 1'b1;

      for (int r = 1; r < dec_pkg::num_regs; r++) begin
         step();
         wb.valid  = 1'b1;
         wb.rd     = 5'(r);
         wb.data   = next_rand();
         regs_m[r] = wb.data;
      end
      step();
      wb.valid = 1'b0;
      for (int k = 0; k < 8; k++) begin
         s0     = rand_slot(dec_pkg::add);
         s1     = rand_slot(dec_pkg::add);
         s0.rs1 = 5'(4 * k);                        // x0 read in the first pair
         s0.rs2 = 5'(4 * k + 1);
         s1.rs1 = 5'(4 * k + 2);
         s1.rs2 = 5'(4 * k + 3);
         send_pair(encode(s0), encode(s1), 2'b11);
      end
      finish_test("register round trip");

      for (int i = 0; i < 34; i++) begin
         s0 = rand_slot(dec_pkg::dec_op_e'(5'(i % 17)));   // every class twice
         s1 = rand_slot(rand_op(17));
         send_pair(s0, s1, 2'b11);
      end
      finish_test("decode of every opcode");

      for (int i = 0; i < 20; i++) begin
         s0        = rand_slot(rand_op(16));
         s1        = rand_slot(rand_op(16));
         s0.rd[4]  = 1'b0;                          // rd below x16
         s1.rs1[4] = 1'b1;                          // sources x16 and up
         s1.rs2[4] = 1'b1;
         send_pair(encode(s0), encode(s1), 2'b11);
      end
      finish_test("dual issue");

      for (int i = 0; i < 20; i++) begin
         s0 = rand_slot(rand_op(16));
         s1 = rand_slot(rand_op(15));               // rr or ri, reads rs1
         if (i % 4 == 3) begin
            s0.rd = 5'd0;                           // x0 target, no split
         end else if (s0.rd == 5'd0) begin
            s0.rd = 5'd1;
         end
         s1.rs1 = s0.rd;
         send_pair(encode(s0), encode(s1), 2'b11);
      end
      finish_test("dependency split");

      rand_ready = 1'b1;
      for (int i = 0; i < 60; i++) begin
         s0 = rand_slot(rand_op(17));
         s1 = rand_slot(rand_op(17));
         send_pair(s0, s1, 2'(next_rand() >> 20));
      end
      finish_test("back-pressure");

      for (int i = 0; i < 12; i++) begin
         s0 = rand_slot(rand_op(16));
         s1 = rand_slot(rand_op(16));
         send_pair(s0, s1, 2'(i % 3));              // none, slot 0 only, slot 1 only
      end
      finish_test("partial pairs");

      $display("tests passed: %0d failed: %0d errors: %0d", n_pass, n_fail, errors);
      if (n_fail == 0 && errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule
